// File: cache_geom_pkg.sv
// Cache geometry definitions
`default_nettype none

package cache_geom_pkg;

  localparam int ADDR_W = 6;   // Word address, 64 words
  localparam int DATA_W = 16;  // One data word

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // L1 splits the address into index (bit 0) and tag (bits 5..1)
  typedef logic [0:0]        l1_index_t;
  typedef logic [ADDR_W-2:0] l1_tag_t;

  // L2 recency, 0 is most recent
  typedef logic [2:0] l2_age_t;

  localparam int L1_WAYS  = 2;
  localparam int L1_SETS  = 2;
  localparam int L2_LINES = 8;  // Fully associative, whole address is the tag

endpackage

`default_nettype wire

// File: bus_pkg.sv
// Request path types
`default_nettype none

package bus_pkg;

  // Entry count of the request FIFO, up to the credit pool size
  typedef logic [1:0] credit_t;

  // Read and write position in the FIFO
  typedef logic [0:0] queue_ptr_t;

endpackage

`default_nettype wire

// File: cache_bus_if.sv
// Cache and memory buses
`timescale 1ns/1ns
`default_nettype none

// L1 to L2 request channel
interface cache_bus_if;
  import cache_geom_pkg::*;

  logic  req;    // Held until ack
  logic  write;
  addr_t addr;
  data_t wdata;
  logic  ack;    // One-cycle pulse
  data_t rdata;  // Valid with ack on reads
  logic  hit;    // L2 held the address

  modport upper (output req, write, addr, wdata, input ack, rdata, hit);
  modport lower (input req, write, addr, wdata, output ack, rdata, hit);
endinterface

// L2 to memory request channel
interface mem_bus_if;
  import cache_geom_pkg::*;

  logic  req;
  logic  write;
  addr_t addr;
  data_t wdata;
  logic  ack;
  data_t rdata;

  modport client (output req, write, addr, wdata, input ack, rdata);
  modport server (input req, write, addr, wdata, output ack, rdata);
endinterface

`default_nettype wire

// File: request_queue.sv
// Credit request FIFO
`timescale 1ns/1ns
`default_nettype none

module request_queue #(
  parameter int QUEUE_DEPTH = 2
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  i_req_valid,
  input  logic                  i_req_write,
  input  cache_geom_pkg::addr_t i_req_addr,
  input  cache_geom_pkg::data_t i_req_wdata,
  input  logic                  i_take,
  output logic                  o_valid,
  output logic                  o_write,
  output cache_geom_pkg::addr_t o_addr,
  output cache_geom_pkg::data_t o_wdata,
  output logic                  o_credit
);
  import cache_geom_pkg::*;
  import bus_pkg::*;

  logic  q_write [QUEUE_DEPTH];
  addr_t q_addr  [QUEUE_DEPTH];
  data_t q_wdata [QUEUE_DEPTH];

  queue_ptr_t wr_ptr;
  queue_ptr_t rd_ptr;
  credit_t    count;   // Entries held

  // Wrap at the last slot
  function automatic queue_ptr_t next_ptr(input queue_ptr_t p);
    return (p == queue_ptr_t'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (i_req_valid)
        wr_ptr <= next_ptr(wr_ptr);  // Sender only sends with a credit
      if (i_take)
        rd_ptr <= next_ptr(rd_ptr);
      if (i_req_valid && !i_take)
        count <= count + 1'b1;
      else if (!i_req_valid && i_take)
        count <= count - 1'b1;
    end
  end

  // Entry storage
  always_ff @(posedge clock)
  begin
    if (i_req_valid)
    begin
      q_write[wr_ptr] <= i_req_write;
      q_addr[wr_ptr]  <= i_req_addr;
      q_wdata[wr_ptr] <= i_req_wdata;
    end
  end

  assign o_valid  = (count != '0);     // Head visible the cycle after a push
  assign o_write  = q_write[rd_ptr];
  assign o_addr   = q_addr[rd_ptr];
  assign o_wdata  = q_wdata[rd_ptr];
  assign o_credit = i_take;            // Slot freed, credit goes back

endmodule

`default_nettype wire

// File: l1_cache.sv
// Two-way write-through L1
`timescale 1ns/1ns
`default_nettype none

module l1_cache (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  i_valid,
  input  logic                  i_write,
  input  cache_geom_pkg::addr_t i_addr,
  input  cache_geom_pkg::data_t i_wdata,
  output logic                  o_take,
  output logic                  o_resp_valid,
  output cache_geom_pkg::data_t o_resp_data,
  output logic                  o_hit_l1,
  output logic                  o_hit_l2,
  cache_bus_if.upper            l2
);
  import cache_geom_pkg::*;

  typedef enum logic [1:0] {IDLE, LOOKUP, WAIT_L2, RESPOND} l1_state_t;

  l1_state_t state;

  data_t   l1_data  [L1_SETS][L1_WAYS];
  l1_tag_t l1_tag   [L1_SETS][L1_WAYS];
  logic    l1_valid [L1_SETS][L1_WAYS];
  logic    l1_lru   [L1_SETS];          // Least recent way of the set

  logic  req_write;  // Request being serviced
  addr_t req_addr;
  data_t req_wdata;

  l1_index_t idx;
  l1_tag_t   tag;
  logic      hit0, hit1, l1_hit;
  logic      hit_way, victim_way, way_sel, fill_way;

  assign idx = req_addr[0];
  assign tag = req_addr[ADDR_W-1:1];

  assign hit0    = l1_valid[idx][0] && (l1_tag[idx][0] == tag);
  assign hit1    = l1_valid[idx][1] && (l1_tag[idx][1] == tag);
  assign l1_hit  = hit0 || hit1;
  assign hit_way = hit1;

  // Invalid way first, else the least recent one
  assign victim_way = !l1_valid[idx][0] ? 1'b0 :
                      !l1_valid[idx][1] ? 1'b1 : l1_lru[idx];
  assign way_sel    = l1_hit ? hit_way : victim_way;

  assign o_take       = (state == IDLE) && i_valid;
  assign o_resp_valid = (state == RESPOND);

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      state  <= IDLE;
      l2.req <= 1'b0;
      for (int s = 0; s < L1_SETS; s++)
      begin
        l1_lru[s] <= 1'b0;
        for (int w = 0; w < L1_WAYS; w++)
          l1_valid[s][w] <= 1'b0;
      end
    end
    else
    begin
      case (state)
        IDLE:
          if (i_valid)
            state <= LOOKUP;
        LOOKUP:
        begin
          if (l1_hit || req_write)
            l1_lru[idx] <= ~way_sel;        // Touched way becomes most recent
          if (req_write)
            l1_valid[idx][way_sel] <= 1'b1; // Write allocate
          if (!l1_hit || req_write)
          begin
            l2.req <= 1'b1;                 // Miss or write-through
            state  <= WAIT_L2;
          end
          else
            state <= RESPOND;
        end
        WAIT_L2:
          if (l2.ack)
          begin
            l2.req <= 1'b0;
            state  <= RESPOND;
            if (!req_write)
            begin
              l1_valid[idx][fill_way] <= 1'b1;  // Read fill
              l1_lru[idx]             <= ~fill_way;
            end
          end
        default:
          state <= IDLE;
      endcase
    end
  end

  // Lines, captured request, response and L2 request fields
  always_ff @(posedge clock)
  begin
    case (state)
      IDLE:
        if (i_valid)
        begin
          req_write <= i_write;
          req_addr  <= i_addr;
          req_wdata <= i_wdata;
        end
      LOOKUP:
      begin
        fill_way    <= way_sel;
        o_hit_l1    <= l1_hit;
        o_hit_l2    <= 1'b0;
        o_resp_data <= req_write ? req_wdata : l1_data[idx][hit_way];
        if (req_write)
        begin
          l1_data[idx][way_sel] <= req_wdata;
          l1_tag[idx][way_sel]  <= tag;
        end
        l2.write <= req_write;
        l2.addr  <= req_addr;
        l2.wdata <= req_wdata;
      end
      WAIT_L2:
        if (l2.ack)
        begin
          o_hit_l2 <= l2.hit && !o_hit_l1;  // Only reported on an L1 miss
          if (!req_write)
          begin
            o_resp_data            <= l2.rdata;
            l1_data[idx][fill_way] <= l2.rdata;
            l1_tag[idx][fill_way]  <= tag;
          end
        end
      default:
      begin
      end
    endcase
  end

endmodule

`default_nettype wire

// File: l2_cache.sv
// Fully associative write-back L2
`timescale 1ns/1ns
`default_nettype none

module l2_cache (
  input  logic       clock,
  input  logic       reset,
  cache_bus_if.lower upper,
  mem_bus_if.client  mem
);
  import cache_geom_pkg::*;

  localparam int LINE_W = $clog2(L2_LINES);

  typedef logic [LINE_W-1:0] line_t;
  typedef enum logic [1:0] {IDLE, LOOKUP, WRITE_BACK, FETCH} l2_state_t;

  l2_state_t state;

  data_t   l2_data  [L2_LINES];
  addr_t   l2_tag   [L2_LINES];
  l2_age_t l2_age   [L2_LINES];
  logic    l2_valid [L2_LINES];
  logic    l2_dirty [L2_LINES];

  logic    hit, victim_dirty;
  logic    touch;    // Access completes this cycle
  logic    install;  // Line gets a new address
  line_t   hit_line, victim, victim_r, line_sel;
  l2_age_t oldest, old_age;

  // Tag search over all lines
  always_comb
  begin
    hit      = 1'b0;
    hit_line = '0;
    for (int i = 0; i < L2_LINES; i++)
    begin
      if (l2_valid[i] && (l2_tag[i] == upper.addr))
      begin
        hit      = 1'b1;
        hit_line = line_t'(i);
      end
    end
  end

  // First invalid line, else the oldest
  always_comb
  begin
    victim = '0;
    oldest = '0;
    for (int i = 0; i < L2_LINES; i++)
    begin
      if (l2_age[i] > oldest)
      begin
        oldest = l2_age[i];
        victim = line_t'(i);
      end
    end
    for (int i = L2_LINES - 1; i >= 0; i--)
      if (!l2_valid[i])
        victim = line_t'(i);
  end

  assign victim_dirty = l2_valid[victim] && l2_dirty[victim];
  assign line_sel     = (state == LOOKUP) ? (hit ? hit_line : victim) : victim_r;
  assign touch        = ((state == LOOKUP) && (hit || (upper.write && !victim_dirty))) ||
                        ((state == WRITE_BACK) && mem.ack && upper.write) ||
                        ((state == FETCH) && mem.ack);
  assign install      = touch && !((state == LOOKUP) && hit);
  assign old_age      = l2_valid[line_sel] ? l2_age[line_sel] : '1;  // Empty line ages everyone

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      state     <= IDLE;
      upper.ack <= 1'b0;
      upper.hit <= 1'b0;
      mem.req   <= 1'b0;
      mem.write <= 1'b0;
      for (int i = 0; i < L2_LINES; i++)
      begin
        l2_valid[i] <= 1'b0;
        l2_dirty[i] <= 1'b0;
        l2_age[i]   <= '0;
      end
    end
    else
    begin
      upper.ack <= touch;
      upper.hit <= touch && (state == LOOKUP) && hit;
      if (touch)
      begin
        for (int i = 0; i < L2_LINES; i++)
        begin
          if (line_t'(i) == line_sel)
            l2_age[i] <= '0;               // Now most recent
          else if (l2_valid[i] && (l2_age[i] < old_age))
            l2_age[i] <= l2_age[i] + 1'b1;
        end
        l2_valid[line_sel] <= 1'b1;
        if (upper.write)
          l2_dirty[line_sel] <= 1'b1;
        else if (install)
          l2_dirty[line_sel] <= 1'b0;      // Clean fill from memory
      end
      case (state)
        IDLE:
          if (upper.req && !upper.ack)     // Ignore the request being acked
            state <= LOOKUP;
        LOOKUP:
          if (hit || (upper.write && !victim_dirty))
            state <= IDLE;
          else if (victim_dirty)
          begin
            mem.req   <= 1'b1;
            mem.write <= 1'b1;             // Victim goes back first
            state     <= WRITE_BACK;
          end
          else
          begin
            mem.req   <= 1'b1;
            mem.write <= 1'b0;
            state     <= FETCH;
          end
        WRITE_BACK:
          if (mem.ack)
          begin
            if (upper.write)
            begin
              mem.req <= 1'b0;
              state   <= IDLE;
            end
            else
            begin
              mem.write <= 1'b0;           // Chain into the line read
              state     <= FETCH;
            end
          end
        default:
          if (mem.ack)
          begin
            mem.req <= 1'b0;
            state   <= IDLE;
          end
      endcase
    end
  end

  // Line payload and bus fields
  always_ff @(posedge clock)
  begin
    if (state == LOOKUP)
    begin
      victim_r  <= victim;
      mem.addr  <= victim_dirty ? l2_tag[victim] : upper.addr;
      mem.wdata <= l2_data[victim];
    end
    else if ((state == WRITE_BACK) && mem.ack)
      mem.addr <= upper.addr;
    if (touch)
    begin
      upper.rdata <= (state == FETCH) ? mem.rdata : l2_data[line_sel];
      if (upper.write)
        l2_data[line_sel] <= upper.wdata;
      else if (install)
        l2_data[line_sel] <= mem.rdata;
      if (install)
        l2_tag[line_sel] <= upper.addr;
    end
  end

endmodule

`default_nettype wire

// File: main_memory.sv
// Fixed latency main memory
`timescale 1ns/1ns
`default_nettype none

module main_memory #(
  parameter int MEM_LATENCY = 2
) (
  input  logic      clock,
  input  logic      reset,
  mem_bus_if.server bus
);
  import cache_geom_pkg::*;

  localparam int MEM_WORDS = 2 ** ADDR_W;
  localparam int CNT_W     = $clog2(MEM_LATENCY + 1);

  data_t            mem [MEM_WORDS];
  logic             busy;
  logic [CNT_W-1:0] cnt;     // Cycles left before ack
  logic             accept;  // New request this cycle
  logic             done;    // Ack goes out next cycle

  assign accept = bus.req && !busy && !bus.ack;
  assign done   = (accept && (MEM_LATENCY <= 1)) || (busy && (cnt == CNT_W'(1)));

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      busy    <= 1'b0;
      cnt     <= '0;
      bus.ack <= 1'b0;
      for (int i = 0; i < MEM_WORDS; i++)
        mem[i] <= data_t'(16'h1000 + i);  // Known pattern
    end
    else
    begin
      bus.ack <= done;
      if (accept && (MEM_LATENCY > 1))
      begin
        busy <= 1'b1;
        cnt  <= CNT_W'(MEM_LATENCY - 1);
      end
      else if (busy)
      begin
        if (done)
          busy <= 1'b0;
        else
          cnt <= cnt - 1'b1;
      end
      if (accept && bus.write)
        mem[bus.addr] <= bus.wdata;  // Address and data held until ack
    end
  end

  always_ff @(posedge clock)
  begin
    if (done)
      bus.rdata <= mem[bus.addr];    // Lines up with ack
  end

endmodule

`default_nettype wire

// File: mem_hierarchy.sv
// Cache hierarchy top level
`timescale 1ns/1ns
`default_nettype none

module mem_hierarchy #(
  parameter int QUEUE_DEPTH = 2,
  parameter int MEM_LATENCY = 2
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  i_req_valid,
  input  logic                  i_req_write,
  input  cache_geom_pkg::addr_t i_req_addr,
  input  cache_geom_pkg::data_t i_req_wdata,
  output logic                  o_credit,
  output logic                  o_resp_valid,
  output cache_geom_pkg::data_t o_resp_data,
  output logic                  o_hit_l1,
  output logic                  o_hit_l2
);
  import cache_geom_pkg::*;

  logic  q_valid, q_write, q_take;  // Queue head to L1
  addr_t q_addr;
  data_t q_wdata;

  cache_bus_if l1_l2_bus ();
  mem_bus_if   l2_mem_bus ();

  request_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
    .clock(clock), .reset(reset),
    .i_req_valid(i_req_valid), .i_req_write(i_req_write),
    .i_req_addr(i_req_addr), .i_req_wdata(i_req_wdata),
    .i_take(q_take),
    .o_valid(q_valid), .o_write(q_write), .o_addr(q_addr), .o_wdata(q_wdata),
    .o_credit(o_credit)
  );

  l1_cache u_l1 (
    .clock(clock), .reset(reset),
    .i_valid(q_valid), .i_write(q_write), .i_addr(q_addr), .i_wdata(q_wdata),
    .o_take(q_take), .o_resp_valid(o_resp_valid), .o_resp_data(o_resp_data),
    .o_hit_l1(o_hit_l1), .o_hit_l2(o_hit_l2),
    .l2(l1_l2_bus.upper)
  );

  l2_cache u_l2 (.clock(clock), .reset(reset), .upper(l1_l2_bus.lower), .mem(l2_mem_bus.client));

  main_memory #(.MEM_LATENCY(MEM_LATENCY)) u_mem (
    .clock(clock), .reset(reset), .bus(l2_mem_bus.server)
  );

endmodule

`default_nettype wire

// File: tb_mem_hierarchy.sv
// Cache hierarchy testbench
`timescale 1ns/1ns
`default_nettype none

module tb_mem_hierarchy;
  import cache_geom_pkg::*;

  localparam int QUEUE_DEPTH    = 2;
  localparam int MEM_LATENCY    = 2;
  localparam int COLD_N         = 4;
  localparam int EVICT_N        = 12;   // More than the eight L2 lines
  localparam int RAND_N         = 200;
  localparam int NUM_REQ        = COLD_N + 2 + 4 + 2 * EVICT_N + RAND_N;
  localparam int TIMEOUT_CYCLES = 400 * NUM_REQ;

  logic  clock = 1'b0;
  logic  reset;
  logic  i_req_valid;
  logic  i_req_write;
  addr_t i_req_addr;
  data_t i_req_wdata;
  logic  o_credit;
  logic  o_resp_valid;
  data_t o_resp_data;
  logic  o_hit_l1;
  logic  o_hit_l2;

  // Reference model state
  data_t mem_img  [64];       // Pattern plus all writes
  addr_t l1_mru   [L1_SETS];  // Most recent address per set
  addr_t l1_lru   [L1_SETS];
  logic  l1_mru_v [L1_SETS];
  logic  l1_lru_v [L1_SETS];
  addr_t l2_recent[$];        // L2 contents, most recent first

  // Requests waiting for a credit
  string pend_name[$];
  logic  pend_write[$];
  addr_t pend_addr[$];
  data_t pend_wdata[$];

  // Expected responses in request order
  string exp_name[$];
  data_t exp_data[$];
  logic  exp_l1[$];
  logic  exp_l2[$];

  int                credits;
  int                req_count;
  int                resp_count;
  int                errors;
  int                cycles;
  logic [31:0]       lcg_state;
  logic [31:0]       rnd;
  logic [DATA_W+1:0] pred;    // {hit_l1, hit_l2, data}

  mem_hierarchy #(.QUEUE_DEPTH(QUEUE_DEPTH), .MEM_LATENCY(MEM_LATENCY)) DUT (
    .clock(clock), .reset(reset),
    .i_req_valid(i_req_valid), .i_req_write(i_req_write),
    .i_req_addr(i_req_addr), .i_req_wdata(i_req_wdata),
    .o_credit(o_credit), .o_resp_valid(o_resp_valid), .o_resp_data(o_resp_data),
    .o_hit_l1(o_hit_l1), .o_hit_l2(o_hit_l2)
  );

  always #2 clock = ~clock;  // 4 ns period

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // One access through the model, L1 and L2 both true LRU
  function automatic logic [DATA_W+1:0] predict_access(input logic wr, input addr_t a,
                                                      input data_t d);
    l1_index_t s;
    logic      hit1;
    int        found;
    s     = a[0];
    hit1  = (l1_mru_v[s] && (l1_mru[s] == a)) || (l1_lru_v[s] && (l1_lru[s] == a));
    found = -1;
    for (int i = 0; i < l2_recent.size(); i++)
      if (l2_recent[i] == a)
        found = i;
    if (!(l1_mru_v[s] && (l1_mru[s] == a)))
    begin
      l1_lru[s]   = l1_mru[s];    // Old recent way drops back, old LRU way leaves
      l1_lru_v[s] = l1_mru_v[s];
      l1_mru[s]   = a;
      l1_mru_v[s] = 1'b1;
    end
    if (wr || !hit1)                // L2 sees L1 misses and every write
    begin
      if (found >= 0)
        l2_recent.delete(found);
      l2_recent.push_front(a);
      if (l2_recent.size() > L2_LINES)
        l2_recent.delete(L2_LINES);  // Least recent line evicted
    end
    if (wr)
      mem_img[a] = d;
    return {hit1, !hit1 && (found >= 0), mem_img[a]};
  endfunction

  task automatic queue_req(input string name, input logic wr, input addr_t a, input data_t d);
    pend_name.push_back(name);
    pend_write.push_back(wr);
    pend_addr.push_back(a);
    pend_wdata.push_back(d);
  endtask

  task automatic print_counts();
    $display("Summary: %0d requests, %0d responses, %0d errors", req_count, resp_count, errors);
  endtask

  // Credits and request drive on the falling edge
  always @(negedge clock)
  begin
    if (o_credit)
    begin
      credits = credits + 1;
      if (credits > QUEUE_DEPTH)
      begin
        $display("credit returned while the sender already held all credits");
        errors = errors + 1;
      end
    end
    if (!reset && (pend_addr.size() > 0) && (credits > 0))
    begin
      i_req_valid = 1'b1;
      i_req_write = pend_write.pop_front();
      i_req_addr  = pend_addr.pop_front();
      i_req_wdata = pend_wdata.pop_front();
      pred        = predict_access(i_req_write, i_req_addr, i_req_wdata);
      exp_name.push_back(pend_name.pop_front());
      exp_l1.push_back(pred[DATA_W+1]);
      exp_l2.push_back(pred[DATA_W]);
      exp_data.push_back(pred[DATA_W-1:0]);
      credits   = credits - 1;
      req_count = req_count + 1;
    end
    else
      i_req_valid = 1'b0;
  end

  task automatic check_resp();
    string nm;
    data_t ed;
    logic  el1;
    logic  el2;
    nm  = exp_name.pop_front();
    ed  = exp_data.pop_front();
    el1 = exp_l1.pop_front();
    el2 = exp_l2.pop_front();
    if (o_resp_data !== ed)
    begin
      $display("mismatch %s resp %0d data: expected %h actual %h", nm, resp_count, ed,
               o_resp_data);
      errors = errors + 1;
    end
    if (o_hit_l1 !== el1)
    begin
      $display("mismatch %s resp %0d hit_l1: expected %b actual %b", nm, resp_count, el1,
               o_hit_l1);
      errors = errors + 1;
    end
    if (o_hit_l2 !== el2)
    begin
      $display("mismatch %s resp %0d hit_l2: expected %b actual %b", nm, resp_count, el2,
               o_hit_l2);
      errors = errors + 1;
    end
  endtask

  // Compare each response against the oldest expectation
  always @(negedge clock)
  begin
    if (o_resp_valid === 1'b1)
    begin
      resp_count = resp_count + 1;
      if (exp_data.size() == 0)
      begin
        $display("response arrived with no request outstanding");
        errors = errors + 1;
      end
      else
        check_resp();
    end
  end

  always @(posedge clock)
  begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT_CYCLES)
    begin
      $display("timeout after %0d cycles, %0d of %0d responses seen", cycles, resp_count,
               NUM_REQ);
      errors = errors + 1;
      print_counts();
      $display("Done: errors found");
      $finish;
    end
  end

  initial
  begin
    reset       = 1'b1;
    i_req_valid = 1'b0;
    i_req_write = 1'b0;
    i_req_addr  = '0;
    i_req_wdata = '0;
    credits     = QUEUE_DEPTH;
    req_count   = 0;
    resp_count  = 0;
    errors      = 0;
    cycles      = 0;
    lcg_state   = 32'h5a7e5e76;
    for (int i = 0; i < 64; i++)
      mem_img[i] = data_t'(32'h1000 + i);  // Word a holds 1000 plus a
    for (int s = 0; s < L1_SETS; s++)
    begin
      l1_mru[s]   = '0;
      l1_lru[s]   = '0;
      l1_mru_v[s] = 1'b0;
      l1_lru_v[s] = 1'b0;
    end
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    @(posedge clock);

    for (int i = 0; i < COLD_N; i++)
      queue_req("cold_read", 1'b0, addr_t'(i * 17), '0);
    queue_req("write_read", 1'b1, 6'h0a, 16'hbeef);
    queue_req("write_read", 1'b0, 6'h0a, '0);       // Should hit in L1
    queue_req("l2_hit", 1'b0, 6'h2c, '0);           // Three even addresses share set 0
    queue_req("l2_hit", 1'b0, 6'h2e, '0);
    queue_req("l2_hit", 1'b0, 6'h28, '0);
    queue_req("l2_hit", 1'b0, 6'h2c, '0);           // Gone from L1, still in L2
    for (int i = 0; i < EVICT_N; i++)
      queue_req("evict_writeback", 1'b1, addr_t'(32'h30 + i), data_t'(32'hc000 + i * 257));
    for (int i = 0; i < EVICT_N; i++)
      queue_req("evict_writeback", 1'b0, addr_t'(32'h30 + i), '0);
    for (int i = 0; i < RAND_N; i++)
    begin
      rnd = lcg_next();
      queue_req("random_mix", rnd[31], rnd[29:24], rnd[15:0]);
    end

    while (resp_count < NUM_REQ)
      @(negedge clock);
    repeat (8) @(negedge clock);  // Leave room for a stray extra response
    if (resp_count != req_count)
    begin
      $display("%0d responses for %0d requests", resp_count, req_count);
      errors = errors + 1;
    end
    if (credits != QUEUE_DEPTH)
    begin
      $display("sender holds %0d credits at the end instead of %0d", credits, QUEUE_DEPTH);
      errors = errors + 1;
    end
    print_counts();
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
cache_geom_pkg.sv
bus_pkg.sv
cache_bus_if.sv
request_queue.sv
l1_cache.sv
l2_cache.sv
main_memory.sv
mem_hierarchy.sv
tb_mem_hierarchy.sv

// File: Makefile
# Verilator simulation of the cache hierarchy

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary -Wno-fatal -f sim.f --top-module tb_mem_hierarchy
	./obj_dir/Vtb_mem_hierarchy > sim.log
	cat sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
